//--- bench/tb_can_irq_top.sv
// CAN interrupt block testbench
`timescale 1ns/1ps
`include "can_irq_defs.svh"

module tb_can_irq_top
    import can_irq_pkg::*;
();

    localparam int DIRECTED_CYCLES = 360;
    localparam int RAND_OPS        = 40;
    localparam int OP_CYCLES_MAX   = 16;
    // Twice the longest expected run
    localparam int TIMEOUT_CYCLES  = 2 * (DIRECTED_CYCLES + RAND_OPS * OP_CYCLES_MAX);
    localparam int SETTLE_CYCLES   = 4;
    localparam int WAIT_LIMIT      = 16;
    localparam irq_vec_t ALL_SRC   = {`CAN_IRQ_SRC_W{1'b1}};

    logic        clk;
    logic        rst_n;
    logic        tx_done;
    logic        rx_done;
    logic        error_detected;
    logic        bus_off;
    logic        cfg_tvalid;
    logic        cfg_tready;
    cfg_word_t   cfg_tdata;
    logic        sts_tvalid;
    logic        sts_tready;
    irq_vec_t    sts_tdata;
    logic        sts_tlast;
    logic        interrupt;

    // Reference model state
    irq_vec_t    model_pend;
    irq_vec_t    model_mask;
    irq_vec_t    cur_lines;

    // Status stream monitor state
    irq_vec_t    last_pkt;
    irq_vec_t    held_data;
    logic        was_stalled;
    int          pkt_count;

    int          err_count;
    int          test_err_start;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;
    logic [31:0] rng_state;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    can_irq_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .tx_done        (tx_done),
        .rx_done        (rx_done),
        .error_detected (error_detected),
        .bus_off        (bus_off),
        .cfg_tvalid     (cfg_tvalid),
        .cfg_tready     (cfg_tready),
        .cfg_tdata      (cfg_tdata),
        .sts_tvalid     (sts_tvalid),
        .sts_tready     (sts_tready),
        .sts_tdata      (sts_tdata),
        .sts_tlast      (sts_tlast),
        .interrupt      (interrupt)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic check_vec(input string name, input irq_vec_t expected, input irq_vec_t actual);
        if (actual !== expected) begin
            $display("Error %s expected 0x%h got 0x%h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error %s expected 0x%h got 0x%h", name, expected, actual);
            err_count++;
        end
    endtask

    // Handshakes seen at the rising edge, before the DUT updates
    always @(posedge clk) begin
        if (rst_n) begin
            if (was_stalled) begin
                check_bit("sts_tvalid", 1'b1, sts_tvalid);
                check_vec("sts_tdata", held_data, sts_tdata);
            end
            if (sts_tvalid && sts_tready) begin
                check_bit("sts_tlast", 1'b1, sts_tlast);
                last_pkt = sts_tdata;
                pkt_count++;
            end
            was_stalled = sts_tvalid && !sts_tready;
            held_data   = sts_tdata;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // One cycle of stimulus, the model follows the same rules as the block
    task automatic drive_step(input irq_vec_t lines, input logic valid, input cfg_word_t word);
        irq_vec_t rising;
        rising         = lines & ~cur_lines;
        tx_done        = lines.tx_done;
        rx_done        = lines.rx_done;
        error_detected = lines.error;
        bus_off        = lines.bus_off;
        cfg_tvalid     = valid;
        cfg_tdata      = word;
        if (valid && word.op == OP_SET_MASK) begin
            model_mask = word.payload;
        end
        if (valid && word.op == OP_CLEAR) begin
            model_pend = model_pend & ~word.payload;
        end
        // Edge in the same cycle as a clear wins
        model_pend = model_pend | rising;
        cur_lines  = lines;
        @(negedge clk);
        cfg_tvalid = 1'b0;
        cfg_tdata  = '0;
    endtask

    task automatic send_cfg(input cfg_op_e op, input irq_vec_t payload);
        cfg_word_t word;
        word.op      = op;
        word.payload = payload;
        drive_step(cur_lines, 1'b1, word);
    endtask

    task automatic pulse_lines(input irq_vec_t bits);
        drive_step(bits, 1'b0, '0);
        drive_step('0, 1'b0, '0);
    endtask

    // Two idle samples in a row mean no packet is about to start
    task automatic wait_stream_idle();
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        while (quiet < 2 && waited < WAIT_LIMIT) begin
            if (sts_tvalid) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            @(negedge clk);
            waited++;
        end
        if (quiet < 2) begin
            $display("Status stream still busy after %0d cycles", waited);
            err_count++;
        end
    endtask

    task automatic wait_valid();
        int waited;
        waited = 0;
        while (!sts_tvalid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!sts_tvalid) begin
            $display("Status stream never raised tvalid");
            err_count++;
        end
    endtask

    task automatic settle();
        idle(SETTLE_CYCLES);
        wait_stream_idle();
    endtask

    task automatic check_model();
        check_bit("interrupt", |(model_pend & model_mask), interrupt);
        check_vec("sts_tdata", model_pend, last_pkt);
    endtask

    task automatic start_test();
        test_err_start = err_count;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_count == test_err_start) begin
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, err_count - test_err_start);
        end
    endtask

    task automatic test_mask_gating();
        start_test();
        check_bit("interrupt", 1'b0, interrupt);
        check_bit("sts_tvalid", 1'b0, sts_tvalid);
        check_bit("sts_tlast", 1'b0, sts_tlast);
        check_bit("cfg_tready", 1'b1, cfg_tready);
        pulse_lines(4'b0001);
        settle();
        check_model();
        check_bit("interrupt", 1'b0, interrupt);
        check_vec("sts_tdata", 4'b0001, last_pkt);
        // Unmasked tx_done shows within two edges
        send_cfg(OP_SET_MASK, 4'b0001);
        if (!interrupt) begin
            @(negedge clk);
        end
        check_bit("interrupt", 1'b1, interrupt);
        finish_test("mask_gating");
    endtask

    task automatic test_event_latency();
        irq_vec_t lines;
        start_test();
        send_cfg(OP_CLEAR, ALL_SRC);
        send_cfg(OP_SET_MASK, 4'b0010);
        settle();
        check_bit("interrupt", 1'b0, interrupt);
        lines         = cur_lines;
        lines.rx_done = 1'b1;
        // First edge after this samples rx_done high
        drive_step(lines, 1'b0, '0);
        check_bit("interrupt", 1'b0, interrupt);
        @(negedge clk);
        check_bit("interrupt", 1'b0, interrupt);
        @(negedge clk);
        check_bit("interrupt", 1'b1, interrupt);
        // Held level, cleared flag stays cleared
        idle(6);
        send_cfg(OP_CLEAR, 4'b0010);
        settle();
        check_model();
        check_bit("interrupt", 1'b0, interrupt);
        lines.rx_done = 1'b0;
        drive_step(lines, 1'b0, '0);
        settle();
        check_model();
        finish_test("event_latency");
    endtask

    task automatic test_clear();
        cfg_word_t word;
        start_test();
        send_cfg(OP_SET_MASK, 4'b1100);
        pulse_lines(4'b1100);
        settle();
        check_model();
        send_cfg(OP_CLEAR, 4'b0100);
        settle();
        check_model();
        check_vec("sts_tdata", 4'b1000, last_pkt);
        check_bit("interrupt", 1'b1, interrupt);
        send_cfg(OP_CLEAR, 4'b1000);
        settle();
        check_model();
        check_bit("interrupt", 1'b0, interrupt);
        pulse_lines(4'b0001);
        settle();
        // Clear and new tx_done edge together
        word.op      = OP_CLEAR;
        word.payload = 4'b0001;
        drive_step(4'b0001, 1'b1, word);
        drive_step(4'b0000, 1'b0, '0);
        settle();
        check_model();
        check_vec("sts_tdata", 4'b0001, last_pkt);
        send_cfg(OP_CLEAR, ALL_SRC);
        settle();
        check_model();
        finish_test("clear");
    endtask

    task automatic test_back_pressure();
        irq_vec_t held;
        start_test();
        sts_tready = 1'b0;
        pulse_lines(4'b0001);
        wait_valid();
        held = sts_tdata;
        check_vec("sts_tdata", model_pend, held);
        pulse_lines(4'b0010);
        pulse_lines(4'b0100);
        idle(SETTLE_CYCLES);
        check_bit("sts_tvalid", 1'b1, sts_tvalid);
        check_vec("sts_tdata", held, sts_tdata);
        sts_tready = 1'b1;
        settle();
        check_model();
        send_cfg(OP_CLEAR, ALL_SRC);
        settle();
        check_model();
        finish_test("back_pressure");
    endtask

    task automatic test_report_request();
        int pkt_before;
        start_test();
        pulse_lines(4'b1000);
        settle();
        check_model();
        pkt_before = pkt_count;
        send_cfg(OP_REPORT, 4'b0000);
        settle();
        if (pkt_count != pkt_before + 1) begin
            $display("Report request gave %0d packets instead of one", pkt_count - pkt_before);
            err_count++;
        end
        check_vec("sts_tdata", 4'b1000, last_pkt);
        finish_test("report_request");
    endtask

    task automatic test_random_run();
        logic [31:0] r;
        irq_vec_t    lines;
        cfg_word_t   word;
        start_test();
        for (int i = 0; i < RAND_OPS; i++) begin
            r     = next_random();
            lines = r[19:16];
            word  = '0;
            case (r[29:28])
                2'd1: begin
                    word.op      = OP_SET_MASK;
                    word.payload = r[23:20];
                end
                2'd2: begin
                    word.op      = OP_CLEAR;
                    word.payload = r[27:24];
                end
                2'd3: begin
                    word.op = OP_REPORT;
                end
                default: begin
                    // NOP words carry a payload that must be ignored
                    word.op      = OP_NOP;
                    word.payload = r[23:20];
                end
            endcase
            drive_step(lines, 1'b1, word);
            if (r[31]) begin
                sts_tready = 1'b0;
                idle(int'(r[15:14]) + 1);
                sts_tready = 1'b1;
            end
            settle();
            check_model();
        end
        finish_test("random_run");
    endtask

    initial begin
        tx_done        = 1'b0;
        rx_done        = 1'b0;
        error_detected = 1'b0;
        bus_off        = 1'b0;
        cfg_tvalid     = 1'b0;
        cfg_tdata      = '0;
        sts_tready     = 1'b1;
        model_pend     = '0;
        model_mask     = '0;
        cur_lines      = '0;
        last_pkt       = '0;
        held_data      = '0;
        was_stalled    = 1'b0;
        pkt_count      = 0;
        err_count      = 0;
        test_err_start = 0;
        tests_run      = 0;
        tests_failed   = 0;
        cycle_count    = 0;
        rng_state      = 32'd65;
        wait (rst_n === 1'b1);
        @(negedge clk);
        test_mask_gating();
        test_event_latency();
        test_clear();
        test_back_pressure();
        test_report_request();
        test_random_run();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 4;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Reset released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- compile.f
+incdir+include
design/can_irq_pkg.sv
design/can_event_detect.sv
design/can_irq_pending.sv
design/can_irq_control.sv
design/can_status_reporter.sv
design/can_irq_top.sv
bench/tb_clock_gen.sv
bench/tb_can_irq_top.sv

//--- design/can_event_detect.sv
// CAN status rising-edge detector
`timescale 1ns/1ps
`include "can_irq_defs.svh"

module can_event_detect
    import can_irq_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     tx_done,
    input  logic     rx_done,
    input  logic     error_detected,
    input  logic     bus_off,
    output irq_vec_t events
);

    logic [`CAN_IRQ_SRC_W-1:0] level_now;
    logic [`CAN_IRQ_SRC_W-1:0] level_q;
    logic [`CAN_IRQ_SRC_W-1:0] events_q;

    // Same bit order as irq_vec_t
    assign level_now = {bus_off, error_detected, rx_done, tx_done};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_q  <= '0;
            events_q <= '0;
        end else begin
            level_q  <= level_now;
            // High now, low at the previous edge
            events_q <= level_now & ~level_q;
        end
    end

    assign events = events_q;

    // A held level must not produce a second pulse
    a_event_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (events_q & $past(events_q)) == '0
    ) else $error("event pulse longer than one cycle");

endmodule

//--- design/can_irq_control.sv
// CAN interrupt configuration decoder
`timescale 1ns/1ps

module can_irq_control
    import can_irq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cfg_tvalid,
    input  cfg_word_t cfg_tdata,
    output logic      cfg_tready,
    input  irq_vec_t  pending,
    output irq_vec_t  clr,
    output logic      report_req,
    output logic      interrupt
);

    irq_vec_t mask_q;
    logic     cfg_fire;
    logic     is_clear;

    // Configuration words are never stalled
    assign cfg_tready = 1'b1;
    assign cfg_fire   = cfg_tvalid && cfg_tready;
    assign is_clear   = cfg_fire && (cfg_tdata.op == OP_CLEAR);

    // Mask register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask_q <= '0;
        end else if (cfg_fire && (cfg_tdata.op == OP_SET_MASK)) begin
            mask_q <= cfg_tdata.payload;
        end
    end

    // Clear and report pulses, one cycle each
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clr        <= '0;
            report_req <= 1'b0;
        end else begin
            clr        <= '0;
            report_req <= 1'b0;
            if (cfg_fire) begin
                unique case (cfg_tdata.op)
                    OP_CLEAR: begin
                        clr <= cfg_tdata.payload;
                    end
                    OP_REPORT: begin
                        report_req <= 1'b1;
                    end
                    OP_SET_MASK: begin
                        // Handled by the mask register
                    end
                    default: begin
                        // OP_NOP
                    end
                endcase
            end
        end
    end

    // Interrupt line, registered from the masked pending flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            interrupt <= 1'b0;
        end else begin
            interrupt <= |(pending & mask_q);
        end
    end

    // Clear bits only ever follow an accepted OP_CLEAR word
    a_clr_after_op_clear: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$past(is_clear) |-> (clr == '0)
    ) else $error("clr driven without an OP_CLEAR word");

endmodule

//--- design/can_irq_pending.sv
// CAN interrupt pending flags
`timescale 1ns/1ps
`include "can_irq_defs.svh"

module can_irq_pending
    import can_irq_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  irq_vec_t events,
    input  irq_vec_t clr,
    output irq_vec_t pending
);

    logic [`CAN_IRQ_SRC_W-1:0] pend_q;
    logic [`CAN_IRQ_SRC_W-1:0] pend_next;
    logic [`CAN_IRQ_SRC_W-1:0] set_bits;
    logic [`CAN_IRQ_SRC_W-1:0] clr_bits;

    assign set_bits = events;
    assign clr_bits = clr;

    // Write one to clear, an event in the same cycle keeps the flag
    assign pend_next = (pend_q & ~clr_bits) | set_bits;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= '0;
        end else begin
            pend_q <= pend_next;
        end
    end

    assign pending = pend_q;

    // Only a clear from the control block may drop a flag
    a_no_spurious_fall: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(pend_q) & ~pend_q & ~$past(clr_bits)) == '0
    ) else $error("pending flag fell without a clear");

endmodule

//--- design/can_irq_pkg.sv
// CAN interrupt block types
`include "can_irq_defs.svh"

package can_irq_pkg;

    // One bit per interrupt source, bus_off at the MSB
    typedef struct packed {
        logic bus_off;
        logic error;
        logic rx_done;
        logic tx_done;
    } irq_vec_t;

    // Configuration stream opcodes
    typedef enum logic [`CAN_IRQ_OP_W-1:0] {
        OP_NOP      = 2'd0,
        OP_SET_MASK = 2'd1,
        OP_CLEAR    = 2'd2,
        OP_REPORT   = 2'd3
    } cfg_op_e;

    // Opcode in the upper bits, payload below
    typedef struct packed {
        cfg_op_e  op;
        irq_vec_t payload;
    } cfg_word_t;

    // Status stream master states
    typedef enum logic {
        RPT_IDLE = 1'b0,
        RPT_SEND = 1'b1
    } rpt_state_e;

endpackage

//--- design/can_irq_top.sv
// CAN interrupt block top level
`timescale 1ns/1ps

module can_irq_top
    import can_irq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // Protocol engine status levels
    input  logic      tx_done,
    input  logic      rx_done,
    input  logic      error_detected,
    input  logic      bus_off,

    // Configuration stream
    input  logic      cfg_tvalid,
    output logic      cfg_tready,
    input  cfg_word_t cfg_tdata,

    // Status stream
    output logic      sts_tvalid,
    input  logic      sts_tready,
    output irq_vec_t  sts_tdata,
    output logic      sts_tlast,

    output logic      interrupt
);

    irq_vec_t events;
    irq_vec_t clr;
    irq_vec_t pending;
    logic     report_req;

    can_event_detect u_event_detect (
        .clk            (clk),
        .rst_n          (rst_n),
        .tx_done        (tx_done),
        .rx_done        (rx_done),
        .error_detected (error_detected),
        .bus_off        (bus_off),
        .events         (events)
    );

    can_irq_pending u_pending (
        .clk     (clk),
        .rst_n   (rst_n),
        .events  (events),
        .clr     (clr),
        .pending (pending)
    );

    can_irq_control u_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_tvalid (cfg_tvalid),
        .cfg_tdata  (cfg_tdata),
        .cfg_tready (cfg_tready),
        .pending    (pending),
        .clr        (clr),
        .report_req (report_req),
        .interrupt  (interrupt)
    );

    can_status_reporter u_reporter (
        .clk        (clk),
        .rst_n      (rst_n),
        .pending    (pending),
        .report_req (report_req),
        .sts_tvalid (sts_tvalid),
        .sts_tready (sts_tready),
        .sts_tdata  (sts_tdata),
        .sts_tlast  (sts_tlast)
    );

endmodule

//--- design/can_status_reporter.sv
// CAN interrupt status stream master
`timescale 1ns/1ps

module can_status_reporter
    import can_irq_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  irq_vec_t pending,
    input  logic     report_req,
    output logic     sts_tvalid,
    input  logic     sts_tready,
    output irq_vec_t sts_tdata,
    output logic     sts_tlast
);

    rpt_state_e state_q;
    irq_vec_t   last_sent_q;
    logic       changed;
    logic       start;
    logic       done;

    assign changed = (pending != last_sent_q);
    // Compare only while idle, so back-pressure never queues a second value
    assign start   = (state_q == RPT_IDLE) && (changed || report_req);
    assign done    = (state_q == RPT_SEND) && sts_tready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= RPT_IDLE;
            last_sent_q <= '0;
        end else begin
            unique case (state_q)
                RPT_IDLE: begin
                    if (start) begin
                        state_q     <= RPT_SEND;
                        last_sent_q <= pending;
                    end
                end
                RPT_SEND: begin
                    if (done) begin
                        state_q <= RPT_IDLE;
                    end
                end
                default: begin
                    state_q <= RPT_IDLE;
                end
            endcase
        end
    end

    // Data captured at packet start, then held until accepted
    always_ff @(posedge clk) begin
        if (start) begin
            sts_tdata <= pending;
        end
    end

    // Every packet is a single beat
    assign sts_tvalid = (state_q == RPT_SEND);
    assign sts_tlast  = sts_tvalid;

    // A stalled beat keeps its data and stays valid
    a_hold_under_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (sts_tvalid && !sts_tready) |=> (sts_tvalid && $stable(sts_tdata))
    ) else $error("status beat changed while stalled");

endmodule

//--- include/can_irq_defs.svh
// CAN interrupt block widths
`ifndef CAN_IRQ_DEFS_SVH
`define CAN_IRQ_DEFS_SVH

// Interrupt sources: tx_done, rx_done, error, bus_off
`define CAN_IRQ_SRC_W 4

// Configuration opcode
`define CAN_IRQ_OP_W 2

// Opcode plus one payload bit per source
`define CAN_CFG_W (`CAN_IRQ_OP_W + `CAN_IRQ_SRC_W)

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the CAN interrupt block testbench with Verilator

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_can_irq_top -o tb_sim \
    && ./obj_dir/tb_sim > "$LOG" 2>&1 \
    || echo "SOME TESTS FAILED" >> "$LOG"

cat "$LOG"

grep -q "SOME TESTS FAILED" "$LOG" && exit 1 || exit 0
